/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := clkcfg_tb
FILELIST  := clkcfg.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* clkcfg.f */
hw/clkcfg_pkg.sv
hw/i2c_host_if.sv
hw/bringup_ctrl.sv
hw/i2c_init.sv
hw/i2c_master.sv
hw/clkcfg_top.sv
verification/i2c_target_model.sv
verification/clkcfg_tb.sv

/* hw/bringup_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module bringup_ctrl #(
    parameter int CNT_W     = 32,
    parameter int RST_BIT   = 24,
    parameter int START_BIT = 25,
    parameter int LED_BIT   = 26
) (
    input  logic       phy_clk125,
    input  logic       arst_n_i,
    output logic [3:0] led_o,
    output logic       rst_int_o,
    output logic       start_o
);

    logic [CNT_W-1:0] cnt_q;
    logic             started_q;

    always_ff @(posedge phy_clk125 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            led_o     <= 4'hf;
            rst_int_o <= 1'b1;
            start_o   <= 1'b0;
            started_q <= 1'b0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            // LEDs are active low
            led_o <= ~cnt_q[LED_BIT +: 4];

            if (cnt_q[RST_BIT]) begin
                rst_int_o <= 1'b0;
            end

            // One pulse per power-up, wrap of the counter does not retrigger
            start_o <= cnt_q[START_BIT] && !started_q;
            if (cnt_q[START_BIT]) begin
                started_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/clkcfg_pkg.sv */
`default_nettype none

package clkcfg_pkg;

    typedef logic [6:0] i2c_addr_t;

    typedef struct packed {
        logic start;
        logic write;
        logic write_multiple;
        logic stop;
    } cmd_flags_t;

    typedef struct packed {
        logic [3:0] rsvd;
        i2c_addr_t  addr;
        cmd_flags_t flags;
    } cmd_view_t;

    typedef struct packed {
        logic [5:0] rsvd;
        logic       last;
        logic [7:0] data;
    } data_view_t;

    // Same 15 bits read as command or as data byte
    typedef union packed {
        cmd_view_t  cmd;
        data_view_t dat;
    } entry_body_t;

    typedef struct packed {
        logic        is_cmd;
        entry_body_t body;
    } init_entry_t;

    localparam i2c_addr_t  SYNTH_ADDR = 7'h60;
    localparam cmd_flags_t WR_BLOCK   = '{start: 1'b1, write: 1'b0,
                                          write_multiple: 1'b1, stop: 1'b1};

    function automatic init_entry_t cmd_word(i2c_addr_t addr, cmd_flags_t flags);
        init_entry_t e;
        e = '0;
        e.is_cmd         = 1'b1;
        e.body.cmd.addr  = addr;
        e.body.cmd.flags = flags;
        return e;
    endfunction

    function automatic init_entry_t data_word(logic [7:0] data, logic last);
        init_entry_t e;
        e = '0;
        e.body.dat.data = data;
        e.body.dat.last = last;
        return e;
    endfunction

    localparam int INIT_LEN = 12;

    // Outputs off, PLL A multisynth block, outputs on
    localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
        cmd_word(SYNTH_ADDR, WR_BLOCK),
        data_word(8'h03, 1'b0),
        data_word(8'hff, 1'b1),
        cmd_word(SYNTH_ADDR, WR_BLOCK),
        data_word(8'h1a, 1'b0),
        data_word(8'h00, 1'b0),
        data_word(8'h01, 1'b0),
        data_word(8'h00, 1'b0),
        data_word(8'h0e, 1'b1),
        cmd_word(SYNTH_ADDR, WR_BLOCK),
        data_word(8'h03, 1'b0),
        data_word(8'h00, 1'b1)
    };

endpackage

`default_nettype wire

/* hw/clkcfg_top.sv */
`timescale 1ns/10ps
`default_nettype none

module clkcfg_top #(
    parameter int PRESCALE  = 80,
    parameter int RST_BIT   = 24,
    parameter int START_BIT = 25,
    parameter int LED_BIT   = 26,
    parameter int CNT_W     = 32
) (
    input  logic       phy_clk125,
    input  logic       arst_n_i,
    input  logic       clk_scl_i,
    input  logic       clk_sda_i,
    output logic       clk_scl_oe_o,
    output logic       clk_sda_oe_o,
    output logic [3:0] led_o,
    output logic       init_busy_o,
    output logic       init_done_o,
    output logic       missed_ack_o
);

    logic rst_int;
    logic start;

    i2c_host_if host_if ();

    bringup_ctrl #(
        .CNT_W     (CNT_W),
        .RST_BIT   (RST_BIT),
        .START_BIT (START_BIT),
        .LED_BIT   (LED_BIT)
    ) u_bringup (
        .phy_clk125 (phy_clk125),
        .arst_n_i   (arst_n_i),
        .led_o      (led_o),
        .rst_int_o  (rst_int),
        .start_o    (start)
    );

    i2c_init u_init (
        .phy_clk125 (phy_clk125),
        .arst_n_i   (arst_n_i),
        .rst_int_i  (rst_int),
        .start_i    (start),
        .host       (host_if.seq),
        .busy_o     (init_busy_o),
        .done_o     (init_done_o)
    );

    i2c_master #(
        .PRESCALE (PRESCALE)
    ) u_master (
        .phy_clk125   (phy_clk125),
        .arst_n_i     (arst_n_i),
        .rst_int_i    (rst_int),
        .host         (host_if.eng),
        .scl_i        (clk_scl_i),
        .sda_i        (clk_sda_i),
        .scl_oe_o     (clk_scl_oe_o),
        .sda_oe_o     (clk_sda_oe_o),
        .missed_ack_o (missed_ack_o)
    );

endmodule

`default_nettype wire

/* hw/i2c_host_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface i2c_host_if;
    import clkcfg_pkg::*;

    // Command stream
    i2c_addr_t  cmd_addr;
    cmd_flags_t cmd_flags;
    logic       cmd_valid;
    logic       cmd_ready;

    // Write data stream
    logic [7:0] wr_data;
    logic       wr_last;
    logic       wr_valid;
    logic       wr_ready;

    modport seq (
        output cmd_addr, cmd_flags, cmd_valid,
        input  cmd_ready,
        output wr_data, wr_last, wr_valid,
        input  wr_ready
    );

    modport eng (
        input  cmd_addr, cmd_flags, cmd_valid,
        output cmd_ready,
        input  wr_data, wr_last, wr_valid,
        output wr_ready
    );

endinterface

`default_nettype wire

/* hw/i2c_init.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_init (
    input  logic       phy_clk125,
    input  logic       arst_n_i,
    input  logic       rst_int_i,
    input  logic       start_i,
    i2c_host_if.seq    host,
    output logic       busy_o,
    output logic       done_o
);
    import clkcfg_pkg::*;

    localparam int IDX_W = (INIT_LEN > 1) ? $clog2(INIT_LEN) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(INIT_LEN - 1);

    logic [IDX_W-1:0] idx_q;
    logic             run_q;
    logic             done_q;
    init_entry_t      entry;
    logic             cmd_xfer;
    logic             wr_xfer;

    assign entry = INIT_TABLE[idx_q];

    // Command view
    assign host.cmd_addr  = entry.body.cmd.addr;
    assign host.cmd_flags = entry.body.cmd.flags;
    assign host.cmd_valid = run_q && entry.is_cmd;

    // Data view
    assign host.wr_data  = entry.body.dat.data;
    assign host.wr_last  = entry.body.dat.last;
    assign host.wr_valid = run_q && !entry.is_cmd;

    assign cmd_xfer = host.cmd_valid && host.cmd_ready;
    assign wr_xfer  = host.wr_valid && host.wr_ready;

    always_ff @(posedge phy_clk125 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idx_q  <= '0;
            run_q  <= 1'b0;
            done_q <= 1'b0;
        end else if (rst_int_i) begin
            idx_q  <= '0;
            run_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (start_i && !run_q && !done_q) begin
                run_q <= 1'b1;
            end

            if (cmd_xfer || wr_xfer) begin
                if (idx_q == LAST_IDX) begin
                    run_q  <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    assign busy_o = run_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

/* hw/i2c_master.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_master #(
    parameter int PRESCALE = 80
) (
    input  logic    phy_clk125,
    input  logic    arst_n_i,
    input  logic    rst_int_i,
    i2c_host_if.eng host,
    input  logic    scl_i,
    input  logic    sda_i,
    output logic    scl_oe_o,
    output logic    sda_oe_o,
    output logic    missed_ack_o
);
    import clkcfg_pkg::*;

    localparam logic [2:0] ST_OFF   = 3'd0;
    localparam logic [2:0] ST_IDLE  = 3'd1;
    localparam logic [2:0] ST_START = 3'd2;
    localparam logic [2:0] ST_BIT   = 3'd3;
    localparam logic [2:0] ST_FETCH = 3'd4;
    localparam logic [2:0] ST_DROP  = 3'd5;
    localparam logic [2:0] ST_STOP  = 3'd6;

    localparam logic [15:0] PRESC_END = 16'(PRESCALE - 1);

    logic [2:0]  state_q;
    logic [1:0]  phase_q;
    logic [15:0] presc_q;
    logic        active_q;
    logic [3:0]  bit_q;
    logic [7:0]  shift_q;
    cmd_flags_t  flags_q;
    logic        addr_byte_q;
    logic        last_q;
    logic        scl_oe_d;
    logic        sda_oe_d;
    logic        phased;
    logic        stall;
    logic        tick;
    logic        phase_end;
    logic        more_bytes;
    logic        has_write;

    assign phased     = (state_q == ST_START) || (state_q == ST_BIT) || (state_q == ST_STOP);
    // SCL released but still low, so the target is stretching
    assign stall      = !scl_oe_o && !scl_i;
    assign tick       = phased && !stall && (presc_q == PRESC_END);
    assign phase_end  = tick && (phase_q == 2'd3);
    assign more_bytes = addr_byte_q || !last_q;
    assign has_write  = host.cmd_flags.write || host.cmd_flags.write_multiple;

    assign host.cmd_ready = (state_q == ST_IDLE);
    assign host.wr_ready  = (state_q == ST_FETCH) || (state_q == ST_DROP);

    // SDA only moves while SCL is low, one quarter after the falling edge
    always_comb begin
        scl_oe_d = 1'b1;
        sda_oe_d = sda_oe_o;
        case (state_q)
            ST_OFF: begin
                scl_oe_d = 1'b0;
                sda_oe_d = 1'b0;
            end
            ST_IDLE: begin
                scl_oe_d = active_q;
                if (!active_q) begin
                    sda_oe_d = 1'b0;
                end
            end
            ST_START: begin
                scl_oe_d = active_q && !phase_q[1];
                if (phase_q != 2'd0) begin
                    sda_oe_d = (phase_q == 2'd3);
                end
            end
            ST_BIT: begin
                scl_oe_d = !phase_q[1];
                if (phase_q != 2'd0) begin
                    sda_oe_d = (bit_q != 4'd8) && !shift_q[7];
                end
            end
            ST_STOP: begin
                scl_oe_d = !phase_q[1];
                sda_oe_d = (phase_q == 2'd1) || (phase_q == 2'd2);
            end
            default: begin
                scl_oe_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge phy_clk125 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_OFF;
            phase_q      <= 2'd0;
            presc_q      <= '0;
            active_q     <= 1'b0;
            scl_oe_o     <= 1'b0;
            sda_oe_o     <= 1'b0;
            missed_ack_o <= 1'b0;
        end else if (rst_int_i) begin
            state_q      <= ST_OFF;
            phase_q      <= 2'd0;
            presc_q      <= '0;
            active_q     <= 1'b0;
            scl_oe_o     <= 1'b0;
            sda_oe_o     <= 1'b0;
            missed_ack_o <= 1'b0;
        end else begin
            scl_oe_o <= scl_oe_d;
            sda_oe_o <= sda_oe_d;

            if (phased && !stall) begin
                presc_q <= tick ? '0 : presc_q + 1'b1;
            end
            if (tick) begin
                phase_q <= phase_q + 1'b1;
            end

            case (state_q)
                ST_OFF: state_q <= ST_IDLE;
                ST_IDLE: begin
                    if (host.cmd_valid) begin
                        if (!has_write) begin
                            if (host.cmd_flags.stop && active_q) begin
                                state_q <= ST_STOP;
                            end
                        end else if (host.cmd_flags.start || !active_q) begin
                            state_q <= ST_START;
                        end else begin
                            state_q <= ST_FETCH;
                        end
                    end
                end
                ST_START: begin
                    if (phase_end) begin
                        state_q  <= ST_BIT;
                        active_q <= 1'b1;
                    end
                end
                ST_BIT: begin
                    if (phase_end && (bit_q == 4'd8)) begin
                        if (sda_i) begin
                            missed_ack_o <= 1'b1;
                            state_q      <= more_bytes ? ST_DROP : ST_STOP;
                        end else if (more_bytes) begin
                            state_q <= ST_FETCH;
                        end else begin
                            state_q <= flags_q.stop ? ST_STOP : ST_IDLE;
                        end
                    end
                end
                ST_FETCH: begin
                    if (host.wr_valid) begin
                        state_q <= ST_BIT;
                    end
                end
                ST_DROP: begin
                    // Swallow the rest of the block after a NACK
                    if (host.wr_valid && (!flags_q.write_multiple || host.wr_last)) begin
                        state_q <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (phase_end) begin
                        state_q  <= ST_IDLE;
                        active_q <= 1'b0;
                    end
                end
                default: state_q <= ST_OFF;
            endcase
        end
    end

    // Byte shifter and transaction context
    always_ff @(posedge phy_clk125) begin
        if (host.cmd_valid && host.cmd_ready) begin
            flags_q     <= host.cmd_flags;
            shift_q     <= {host.cmd_addr, 1'b0};
            addr_byte_q <= host.cmd_flags.start || !active_q;
            last_q      <= 1'b0;
            bit_q       <= 4'd0;
        end
        if ((state_q == ST_FETCH) && host.wr_valid) begin
            shift_q     <= host.wr_data;
            addr_byte_q <= 1'b0;
            last_q      <= !flags_q.write_multiple || host.wr_last;
            bit_q       <= 4'd0;
        end
        if ((state_q == ST_BIT) && phase_end && (bit_q != 4'd8)) begin
            shift_q <= {shift_q[6:0], 1'b0};
            bit_q   <= bit_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verification/clkcfg_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module clkcfg_tb;
    import clkcfg_pkg::*;

    localparam int PRESCALE    = 4;
    localparam int RST_BIT     = 5;
    localparam int START_BIT   = 6;
    localparam int LED_BIT     = 3;
    localparam int MAX_STRETCH = 20;
    localparam int RUNS        = 5;
    localparam int CYCLE_LIMIT = 2 * RUNS * ((1 << START_BIT)
        + INIT_LEN * 9 * 4 * PRESCALE + INIT_LEN * 9 * MAX_STRETCH);

    logic       phy_clk125;
    logic       arst_n;
    logic       scl_oe;
    logic       sda_oe;
    logic       scl_bus;
    logic       sda_bus;
    logic [3:0] led;
    logic       busy;
    logic       done;
    logic       missed;
    logic       tgt_scl_low;
    logic       tgt_sda_low;
    logic [4:0] stretch;
    logic       stretch_en;
    int         nack_idx;
    integer     seed;
    int         errors;
    int         hb_errors;
    int         checks;
    int         tests;
    int         cycles;
    logic [31:0] ref_cnt;
    logic [3:0]  exp_led;
    logic [7:0]  exp_bytes [16][16];
    int          exp_len [16];
    int          exp_nframes;

    // Pulled-up open drain bus
    assign scl_bus = !(scl_oe || tgt_scl_low);
    assign sda_bus = !(sda_oe || tgt_sda_low);

    clkcfg_top #(
        .PRESCALE (PRESCALE), .RST_BIT (RST_BIT), .START_BIT (START_BIT),
        .LED_BIT (LED_BIT), .CNT_W (32)
    ) u_dut (
        .phy_clk125 (phy_clk125), .arst_n_i (arst_n),
        .clk_scl_i (scl_bus), .clk_sda_i (sda_bus),
        .clk_scl_oe_o (scl_oe), .clk_sda_oe_o (sda_oe), .led_o (led),
        .init_busy_o (busy), .init_done_o (done), .missed_ack_o (missed)
    );

    i2c_target_model u_tgt (
        .phy_clk125 (phy_clk125), .arst_n_i (arst_n), .scl_i (scl_bus),
        .sda_i (sda_bus), .stretch_i (stretch), .nack_idx_i (nack_idx),
        .scl_low_o (tgt_scl_low), .sda_low_o (tgt_sda_low)
    );

    initial begin
        phy_clk125 = 1'b0;
        forever #5 phy_clk125 = ~phy_clk125;
    end

    task automatic expect_that(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("[ERROR] %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // Reference counter that the LEDs follow one cycle late
    always @(posedge phy_clk125 or negedge arst_n) begin
        if (!arst_n) begin
            ref_cnt <= '0;
            exp_led <= 4'hf;
        end else begin
            ref_cnt <= ref_cnt + 32'd1;
            exp_led <= ~ref_cnt[LED_BIT +: 4];
        end
    end

    always @(negedge phy_clk125) begin
        if (arst_n) begin
            checks++;
            assert (led == exp_led) else begin
                $display("[ERROR] %0t: led_o %h, expected %h", $time, led, exp_led);
                errors++;
                hb_errors++;
            end
        end
        stretch <= stretch_en ? 5'($unsigned($random(seed)) % (MAX_STRETCH + 1)) : 5'd0;
    end

    always @(posedge phy_clk125) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic apply_reset(input bit watch);
        @(negedge phy_clk125);
        arst_n <= 1'b0;
        repeat (16) begin
            @(negedge phy_clk125);
            if (watch) begin
                expect_that(!scl_oe && !sda_oe, "oe outputs active in reset");
                expect_that(!busy && !done && !missed, "status outputs set in reset");
            end
        end
        arst_n <= 1'b1;
    endtask

    function automatic void build_expected(input int nack);
        bit cut;
        exp_nframes = 0;
        cut = 1'b0;
        for (int k = 0; k < INIT_LEN; k++) begin
            if (INIT_TABLE[k].is_cmd) begin
                exp_len[exp_nframes] = 1;
                exp_bytes[exp_nframes][0] = {INIT_TABLE[k].body.cmd.addr, 1'b0};
                cut = (k == nack);
            end else begin
                if (!cut) begin
                    exp_bytes[exp_nframes][exp_len[exp_nframes]] = INIT_TABLE[k].body.dat.data;
                    exp_len[exp_nframes]++;
                    cut = (k == nack);
                end
                if (INIT_TABLE[k].body.dat.last) begin
                    exp_nframes++;
                end
            end
        end
    endfunction

    task automatic compare_frames();
        expect_that(u_tgt.nframes == exp_nframes,
            $sformatf("%0d frames, expected %0d", u_tgt.nframes, exp_nframes));
        for (int f = 0; f < exp_nframes && f < u_tgt.nframes; f++) begin
            expect_that(u_tgt.flen[f] == exp_len[f],
                $sformatf("frame %0d has %0d bytes, expected %0d", f, u_tgt.flen[f], exp_len[f]));
            for (int i = 0; i < exp_len[f] && i < u_tgt.flen[f]; i++) begin
                expect_that(u_tgt.fbytes[f][i] == exp_bytes[f][i],
                    $sformatf("frame %0d byte %0d is %h, expected %h",
                              f, i, u_tgt.fbytes[f][i], exp_bytes[f][i]));
            end
        end
    endtask

    task automatic run_sequence(input bit stretch_on, input int nack);
        stretch_en <= stretch_on;
        nack_idx   <= nack;
        build_expected(nack);
        apply_reset(1'b0);
        // Done rises while the last frame is still on the wire
        while (!(done && !u_tgt.in_frame && !scl_oe && !sda_oe)) begin
            @(negedge phy_clk125);
        end
        compare_frames();
        expect_that(!busy, "init_busy_o high after done");
        expect_that(missed == (nack >= 0), $sformatf("missed_ack_o is %b", missed));
    endtask

    task automatic report_test(input string name, input int fails);
        tests++;
        $display("%-10s %s", name, (fails == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        int err0;
        int wait_cycles;
        int nack_pick;
        seed        = 32'hddb844f9;
        errors      = 0;
        hb_errors   = 0;
        checks      = 0;
        tests       = 0;
        cycles      = 0;
        arst_n      = 1'b0;
        stretch     = 5'd0;
        stretch_en  = 1'b0;
        nack_idx    = -1;
        nack_pick   = int'($unsigned($random(seed)) % INIT_LEN);
        wait_cycles = int'($unsigned($random(seed)) % 150);

        err0 = errors - hb_errors;
        run_sequence(1'b0, -1);
        report_test("clean", errors - hb_errors - err0);

        err0 = errors - hb_errors;
        run_sequence(1'b1, -1);
        report_test("stretch", errors - hb_errors - err0);

        err0 = errors - hb_errors;
        run_sequence(1'b0, nack_pick);
        report_test("nack", errors - hb_errors - err0);

        err0 = errors - hb_errors;
        stretch_en <= 1'b0;
        nack_idx   <= 0;
        apply_reset(1'b0);
        // First address is NACKed, reset lands inside the second frame
        while (!(missed && u_tgt.nframes > 0 && u_tgt.in_frame)) begin
            @(negedge phy_clk125);
        end
        repeat (wait_cycles) @(negedge phy_clk125);
        apply_reset(1'b1);
        run_sequence(1'b0, -1);
        report_test("reset", errors - hb_errors - err0);

        report_test("heartbeat", hb_errors);

        $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/i2c_target_model.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_target_model (
    input  logic       phy_clk125,
    input  logic       arst_n_i,
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic [4:0] stretch_i,
    input  int         nack_idx_i,
    output logic       scl_low_o,
    output logic       sda_low_o
);

    // Frame log, read by the testbench
    logic [7:0] fbytes [16][16];
    int         flen [16];
    int         nframes;
    logic       in_frame;

    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;
    logic       ack_phase;
    logic [7:0] shreg;
    int         cur_len;
    int         byte_idx;
    logic [4:0] hold_q;

    assign scl_low_o = (hold_q != 5'd0);

    always @(negedge phy_clk125 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            in_frame  <= 1'b0;
            bit_cnt   <= 4'd0;
            ack_phase <= 1'b0;
            shreg     <= 8'h00;
            cur_len   <= 0;
            byte_idx  <= 0;
            nframes   <= 0;
            hold_q    <= 5'd0;
            sda_low_o <= 1'b0;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;
            if (hold_q != 5'd0) begin
                hold_q <= hold_q - 5'd1;
            end
            if (scl_q && scl_i && sda_q && !sda_i) begin
                // Start condition
                in_frame  <= 1'b1;
                bit_cnt   <= 4'd0;
                ack_phase <= 1'b0;
                cur_len   <= 0;
            end else if (in_frame && scl_q && scl_i && !sda_q && sda_i) begin
                if (nframes < 16) begin
                    flen[nframes] <= cur_len;
                end
                nframes  <= nframes + 1;
                in_frame <= 1'b0;
            end else if (in_frame && !scl_q && scl_i) begin
                if (bit_cnt < 4'd8) begin
                    shreg   <= {shreg[6:0], sda_i};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (in_frame && scl_q && !scl_i) begin
                if (stretch_i != 5'd0) begin
                    hold_q <= stretch_i;
                end
                if (ack_phase) begin
                    sda_low_o <= 1'b0;
                    ack_phase <= 1'b0;
                    bit_cnt   <= 4'd0;
                end else if (bit_cnt == 4'd8) begin
                    if (nframes < 16 && cur_len < 16) begin
                        fbytes[nframes][cur_len] <= shreg;
                    end
                    cur_len   <= cur_len + 1;
                    byte_idx  <= byte_idx + 1;
                    // Released line reads as NACK
                    sda_low_o <= (byte_idx != nack_idx_i);
                    ack_phase <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
